// File: dv/uart_echo_asserts.sv
`timescale 1ns/1ps

module uart_echo_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input uart_pkg::echo_state_e state,
  input logic                  tx_start,
  input logic                  rx_take,
  input logic                  tx_busy,
  input logic                  frame_err,
  input logic                  overrun
);

  int fail_count = 0;

  // A start pulse must find the transmitter idle
  start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else begin
      $error("tx_start while tx_busy is high");
      fail_count++;
    end

  start_with_take: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start == rx_take)
    else begin
      $error("tx_start and rx_take differ");
      fail_count++;
    end

  // Transmitter stays busy through send except on the start cycle and the cycle busy falls
  send_tracks_busy: assert property (@(posedge clk) disable iff (!rst_n)
    ((state == uart_pkg::echo_send) && !tx_start) |-> (tx_busy || $fell(tx_busy)))
    else begin
      $error("echo_ctrl in send while the transmitter is idle");
      fail_count++;
    end

  frame_err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    !$fell(frame_err))
    else begin
      $error("frame_err fell without reset");
      fail_count++;
    end

  overrun_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    !$fell(overrun))
    else begin
      $error("overrun fell without reset");
      fail_count++;
    end

endmodule

bind echo_ctrl uart_echo_asserts asserts_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .state    (state),
  .tx_start (tx_start),
  .rx_take  (rx_take),
  .tx_busy  (tx_busy),
  .frame_err(frame_err),
  .overrun  (overrun)
);

// File: dv/uart_echo_tb.sv
`timescale 1ns/1ps

module uart_echo_tb;

  localparam int cpb        = 8;
  localparam int short_stop = cpb / 2 + 1;  // Just past the stop sample point
  localparam int n_rows     = 25;
  localparam int burst_at   = 7;            // First row of the overrun burst
  localparam int frame_ns   = 10 * cpb * 8;
  localparam logic [1:0] echo_no    = 2'd0;
  localparam logic [1:0] echo_yes   = 2'd1;
  localparam logic [1:0] echo_maybe = 2'd2;  // Burst byte that may be dropped

  typedef struct packed {
    logic [7:0] data;
    logic       stop_good;
    logic       ignore_cts;
    logic       short_stop;
    logic       use_lfsr;
    logic [1:0] echo;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        rx_in;
  logic        tx_out;
  logic        clear_to_send_n;
  logic        frame_err;
  logic        overrun;
  row_t        table_rows [n_rows];
  logic [31:0] lfsr_state;
  logic [7:0]  got_q [$];
  logic [7:0]  exp_data_q [$];
  logic        exp_must_q [$];
  int          errors;
  logic        exp_frame_err;
  logic        held_busy_seen;

  uart_echo_top #(
    .clocks_per_baud(cpb)
  ) dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_in          (rx_in),
    .tx_out         (tx_out),
    .clear_to_send_n(clear_to_send_n),
    .frame_err      (frame_err),
    .overrun        (overrun)
  );

  always #4 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  task automatic next_random_byte(output logic [7:0] b);
    logic fb;
    for (int i = 0; i < 8; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      b          = {fb, b[7:1]};
    end
  endtask

  task automatic expect_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic build_table();
    table_rows[0] = '{8'h55, 1'b1, 1'b0, 1'b0, 1'b0, echo_yes};
    table_rows[1] = '{8'ha3, 1'b1, 1'b0, 1'b0, 1'b0, echo_yes};
    table_rows[2] = '{8'h00, 1'b1, 1'b1, 1'b0, 1'b1, echo_yes};  // Lands while busy
    table_rows[3] = '{8'h0f, 1'b1, 1'b0, 1'b0, 1'b0, echo_yes};
    table_rows[4] = '{8'h3c, 1'b0, 1'b0, 1'b0, 1'b0, echo_no};   // Low stop bit
    table_rows[5] = '{8'h00, 1'b1, 1'b0, 1'b0, 1'b1, echo_yes};
    table_rows[6] = '{8'hc9, 1'b1, 1'b0, 1'b0, 1'b0, echo_yes};
    for (int i = burst_at; i < n_rows; i++) begin
      table_rows[i] = '{8'h00, 1'b1, 1'b1, 1'b1, 1'b1,
                        (i < burst_at + 2) ? echo_yes : echo_maybe};
    end
  endtask

  // Entered and left on a rising edge
  task automatic send_frame(input logic [7:0] data, input logic stop_good,
                            input int stop_len);
    rx_in <= 1'b0;
    repeat (cpb) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      rx_in <= data[i];  // LSB first
      repeat (cpb) @(posedge clk);
    end
    rx_in <= stop_good;
    repeat (stop_len) @(posedge clk);
    if (!stop_good) begin
      rx_in <= 1'b1;  // Idle so the next start is a clean edge
      repeat (cpb) @(posedge clk);
    end
  endtask

  task automatic wait_for_cts();
    do begin
      @(negedge clk);
      if (clear_to_send_n && dut_i.tx_busy) begin
        held_busy_seen = 1'b1;
      end
    end while (clear_to_send_n);
  endtask

  // Echo finished when the line and clear-to-send rest for a while
  task automatic wait_until_quiet();
    int quiet;
    quiet = 0;
    while (quiet < 12 * cpb) begin
      @(negedge clk);
      quiet = (tx_out && !clear_to_send_n) ? quiet + 1 : 0;
    end
  endtask

  task automatic compare_echoes();
    int gi;
    int skipped;
    gi      = 0;
    skipped = 0;
    for (int i = 0; i < exp_data_q.size(); i++) begin
      if (gi < got_q.size() && got_q[gi] == exp_data_q[i]) begin
        gi++;
      end else if (exp_must_q[i]) begin
        $display("CHECK FAILED: tx_out byte %0d got %h expected %h", i,
                 (gi < got_q.size()) ? got_q[gi] : 8'hxx, exp_data_q[i]);
        errors++;
      end else begin
        skipped++;
      end
    end
    if (gi != got_q.size()) begin
      $display("Unexpected extra bytes were echoed on tx_out");
      errors++;
    end
    if (skipped == 0) begin
      $display("No byte was dropped during the overrun burst");
      errors++;
    end
  endtask

  // Decoder samples each bit in its middle on the falling edge
  initial begin
    logic [7:0] b;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (!tx_out) begin
        repeat (cpb / 2 - 1) @(negedge clk);
        if (tx_out) begin
          $display("Start bit on tx_out did not last to its middle");
          errors++;
        end
        for (int i = 0; i < 8; i++) begin
          repeat (cpb) @(negedge clk);
          b[i] = tx_out;
        end
        repeat (cpb) @(negedge clk);
        if (!tx_out) begin
          $display("Stop bit on tx_out was low");
          errors++;
        end
        got_q.push_back(b);
      end
    end
  end

  initial begin
    #(n_rows * 40 * frame_ns);
    $display("Watchdog expired before the test finished");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    row_t r;
    clk            = 1'b0;
    rst_n          = 1'b0;
    rx_in          = 1'b1;
    errors         = 0;
    lfsr_state     = 32'hac0d_b6fd;
    exp_frame_err  = 1'b0;
    held_busy_seen = 1'b0;
    build_table();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4 * cpb) begin
      @(negedge clk);
      expect_level("tx_out", tx_out, 1'b1);
      expect_level("clear_to_send_n", clear_to_send_n, 1'b0);
      expect_level("frame_err", frame_err, 1'b0);
      expect_level("overrun", overrun, 1'b0);
    end
    @(posedge clk);
    for (int i = 0; i < n_rows; i++) begin
      r = table_rows[i];
      if (r.use_lfsr) begin
        next_random_byte(r.data);
      end
      if (!r.ignore_cts) begin
        wait_for_cts();
        expect_level("frame_err", frame_err, exp_frame_err);
        expect_level("overrun", overrun, 1'b0);
        @(posedge clk);
      end
      if (r.stop_good && r.echo != echo_no) begin
        exp_data_q.push_back(r.data);
        exp_must_q.push_back(r.echo == echo_yes);
      end
      send_frame(r.data, r.stop_good, r.short_stop ? short_stop : cpb);
      if (!r.stop_good) begin
        exp_frame_err = 1'b1;
      end
    end
    rx_in <= 1'b1;
    wait_until_quiet();
    expect_level("frame_err", frame_err, 1'b1);
    expect_level("overrun", overrun, 1'b1);
    if (!held_busy_seen) begin
      $display("clear_to_send_n never read high while a byte waited for a busy transmitter");
      errors++;
    end
    compare_echoes();
    if (dut_i.ctrl_i.asserts_i.fail_count != 0) begin
      $display("Assertions on the echo controller failed %0d times",
               dut_i.ctrl_i.asserts_i.fail_count);
      errors += dut_i.ctrl_i.asserts_i.fail_count;
    end
    $display("Errors: %0d, bytes echoed: %0d", errors, got_q.size());
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
src/uart_pkg.sv
src/uart_rx.sv
src/echo_ctrl.sv
src/uart_tx.sv
src/uart_echo_top.sv
dv/uart_echo_asserts.sv
dv/uart_echo_tb.sv

// File: src/echo_ctrl.sv
`timescale 1ns/1ps

module echo_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::uart_byte_t rx_byte,
  input  logic                 rx_valid,
  output logic                 rx_take,
  output logic [7:0]           tx_data,
  output logic                 tx_start,
  input  logic                 tx_busy,
  input  logic                 frame_err_pulse,
  input  logic                 overrun_pulse,
  output logic                 frame_err,
  output logic                 overrun
);

  uart_pkg::echo_state_e state;
  logic                  tx_busy_q;
  logic                  fire;
  logic                  tx_done;

  // Clean byte waiting and transmitter free
  assign fire    = (state == uart_pkg::echo_idle) && rx_valid && !tx_busy &&
                   !rx_byte.frame_err;
  assign tx_done = tx_busy_q && !tx_busy;  // Falling edge of busy

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= uart_pkg::echo_idle;
      tx_busy_q <= 1'b0;
      tx_start  <= 1'b0;
      rx_take   <= 1'b0;
    end else begin
      tx_busy_q <= tx_busy;
      tx_start  <= fire;
      rx_take   <= fire;  // Frees the holding register with the start
      case (state)
        uart_pkg::echo_idle: begin
          if (fire) begin
            state <= uart_pkg::echo_send;
          end
        end
        uart_pkg::echo_send: begin
          if (tx_done) begin
            state <= uart_pkg::echo_idle;
          end
        end
        default: begin
          state <= uart_pkg::echo_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      tx_data <= rx_byte.data;
    end
  end

  // Sticky status, cleared by reset only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_err <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      frame_err <= frame_err | frame_err_pulse;
      overrun   <= overrun | overrun_pulse;
    end
  end

endmodule

// File: src/uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top #(
  parameter int clocks_per_baud = uart_pkg::default_clocks_per_baud
) (
  input  logic clk,
  input  logic rst_n,
  input  logic rx_in,
  output logic tx_out,
  output logic clear_to_send_n,
  output logic frame_err,
  output logic overrun
);

  uart_pkg::uart_byte_t rx_byte;
  logic                 rx_valid;
  logic                 rx_take;
  logic                 clear_to_send;
  logic                 frame_err_pulse;
  logic                 overrun_pulse;
  logic [7:0]           tx_data;
  logic                 tx_start;
  logic                 tx_busy;

  uart_rx #(
    .clocks_per_baud(clocks_per_baud)
  ) rx_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx             (rx_in),
    .rx_take        (rx_take),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .clear_to_send  (clear_to_send),
    .frame_err_pulse(frame_err_pulse),
    .overrun_pulse  (overrun_pulse)
  );

  echo_ctrl ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .rx_take        (rx_take),
    .tx_data        (tx_data),
    .tx_start       (tx_start),
    .tx_busy        (tx_busy),
    .frame_err_pulse(frame_err_pulse),
    .overrun_pulse  (overrun_pulse),
    .frame_err      (frame_err),
    .overrun        (overrun)
  );

  uart_tx #(
    .clocks_per_baud(clocks_per_baud)
  ) tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_data (tx_data),
    .tx_start(tx_start),
    .tx_busy (tx_busy),
    .tx      (tx_out)
  );

  assign clear_to_send_n = ~clear_to_send;  // Pin is active low

endmodule

// File: src/uart_pkg.sv
package uart_pkg;

  // Baud divider used when the top level is not overridden
  parameter int default_clocks_per_baud = 16;

  // One received character as it leaves the receiver
  typedef struct packed {
    logic       frame_err;  // Stop bit sampled low
    logic [7:0] data;
  } uart_byte_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  typedef enum logic {
    echo_idle,
    echo_send
  } echo_state_e;

endpackage

// File: src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int clocks_per_baud = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  input  logic                rx_take,
  output uart_pkg::uart_byte_t rx_byte,
  output logic                rx_valid,
  output logic                clear_to_send,
  output logic                frame_err_pulse,
  output logic                overrun_pulse
);

  localparam int cnt_w = $clog2(clocks_per_baud + 1);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clocks_per_baud / 2 - 1);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clocks_per_baud - 1);

  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic                rx_fall;
  uart_pkg::rx_state_e state;
  logic [cnt_w-1:0]    cnt;
  logic [2:0]          bit_cnt;
  logic [7:0]          shift_reg;
  logic                bit_tick;
  logic                stop_tick;
  logic                load_hold;

  // Two-stage synchronizer plus one stage for edge detection
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_fall   = rx_prev & ~rx_sync;
  assign bit_tick  = (cnt == last_cnt);
  assign stop_tick = (state == uart_pkg::rx_stop) && bit_tick;
  assign load_hold = stop_tick && !rx_valid;  // Never overwrite a held byte

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= uart_pkg::rx_idle;
      cnt             <= '0;
      bit_cnt         <= '0;
      rx_valid        <= 1'b0;
      frame_err_pulse <= 1'b0;
      overrun_pulse   <= 1'b0;
    end else begin
      frame_err_pulse <= stop_tick && !rx_sync;
      overrun_pulse   <= stop_tick && rx_sync && rx_valid;
      if (load_hold && rx_sync) begin
        rx_valid <= 1'b1;
      end else if (rx_take) begin
        rx_valid <= 1'b0;
      end
      case (state)
        uart_pkg::rx_idle: begin
          cnt <= '0;
          if (rx_fall) begin
            state <= uart_pkg::rx_start;
          end
        end
        uart_pkg::rx_start: begin
          if (cnt == half_cnt) begin  // Middle of the start bit
            cnt     <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;  // Glitch rejected
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::rx_data: begin
          if (bit_tick) begin
            cnt     <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= uart_pkg::rx_stop;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::rx_stop: begin
          if (bit_tick) begin
            cnt   <= '0;
            state <= uart_pkg::rx_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= uart_pkg::rx_idle;
        end
      endcase
    end
  end

  // Data path, LSB arrives first
  always_ff @(posedge clk) begin
    if (state == uart_pkg::rx_data && bit_tick) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
    if (load_hold) begin
      rx_byte.data      <= shift_reg;
      rx_byte.frame_err <= ~rx_sync;
    end
  end

  assign clear_to_send = ~rx_valid;

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int clocks_per_baud = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_data,
  input  logic       tx_start,
  output logic       tx_busy,
  output logic       tx
);

  localparam int cnt_w = $clog2(clocks_per_baud + 1);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clocks_per_baud - 1);

  uart_pkg::tx_state_e state;
  logic [cnt_w-1:0]    cnt;
  logic [2:0]          bit_cnt;
  logic [7:0]          shift_reg;
  logic                bit_tick;
  logic                load;
  logic                shift;

  assign bit_tick = (cnt == last_cnt);
  assign load     = (state == uart_pkg::tx_idle) && tx_start;  // Start ignored when busy
  assign shift    = bit_tick &&
                    ((state == uart_pkg::tx_start) || (state == uart_pkg::tx_data));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::tx_idle;
      cnt     <= '0;
      bit_cnt <= '0;
      tx      <= 1'b1;  // Line idles high
    end else begin
      case (state)
        uart_pkg::tx_idle: begin
          cnt     <= '0;
          bit_cnt <= '0;
          if (load) begin
            tx    <= 1'b0;  // Start bit
            state <= uart_pkg::tx_start;
          end
        end
        uart_pkg::tx_start: begin
          if (bit_tick) begin
            cnt   <= '0;
            tx    <= shift_reg[0];
            state <= uart_pkg::tx_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::tx_data: begin
          if (bit_tick) begin
            cnt     <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              tx    <= 1'b1;  // Stop bit
              state <= uart_pkg::tx_stop;
            end else begin
              tx <= shift_reg[0];
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::tx_stop: begin
          if (bit_tick) begin
            cnt   <= '0;
            state <= uart_pkg::tx_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= uart_pkg::tx_idle;
        end
      endcase
    end
  end

  // Next bit to send always sits in bit 0
  always_ff @(posedge clk) begin
    if (load) begin
      shift_reg <= tx_data;
    end else if (shift) begin
      shift_reg <= {1'b1, shift_reg[7:1]};
    end
  end

  assign tx_busy = (state != uart_pkg::tx_idle);

endmodule
